/* Makefile */
BIN = obj_dir/Vtb_chiplet_node
SRCS = noc_settings.svh chiplet_types_pkg.sv sync_fifo.sv tx_fsm.sv endpoint.sv \
       noc_switch.sv chiplet_node_top.sv tb_chiplet_node.sv

$(BIN): sim.f $(SRCS)
	verilator --binary -Wno-fatal -f sim.f --top-module tb_chiplet_node -o Vtb_chiplet_node

run: $(BIN)
	$(BIN) | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* chiplet_node_top.sv */
`default_nettype none

`include "noc_settings.svh"

module chiplet_node_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [31:0]            bus0_addr,
    input  logic                   bus0_wen,
    input  logic                   bus0_ren,
    input  logic [`NOC_FLIT_W-1:0] bus0_wdata,
    output logic [`NOC_FLIT_W-1:0] bus0_rdata,
    output logic                   bus0_error,
    output logic                   bus0_stall,
    input  logic [31:0]            bus1_addr,
    input  logic                   bus1_wen,
    input  logic                   bus1_ren,
    input  logic [`NOC_FLIT_W-1:0] bus1_wdata,
    output logic [`NOC_FLIT_W-1:0] bus1_rdata,
    output logic                   bus1_error,
    output logic                   bus1_stall,
    output logic                   packet_recv0,
    output logic                   packet_recv1
);
    logic                   tx0_req;
    logic                   tx0_ack;
    logic [`NOC_FLIT_W-1:0] tx0_flit;
    logic                   tx1_req;
    logic                   tx1_ack;
    logic [`NOC_FLIT_W-1:0] tx1_flit;
    logic                   rx0_req;
    logic                   rx0_ack;
    logic [`NOC_FLIT_W-1:0] rx0_flit;
    logic                   rx1_req;
    logic                   rx1_ack;
    logic [`NOC_FLIT_W-1:0] rx1_flit;

    endpoint #(
        .NODE_ID(0)
    ) ep0 (
        .clk(clk),
        .reset(reset),
        .bus_addr(bus0_addr),
        .bus_wen(bus0_wen),
        .bus_ren(bus0_ren),
        .bus_wdata(bus0_wdata),
        .bus_rdata(bus0_rdata),
        .bus_error(bus0_error),
        .bus_stall(bus0_stall),
        .tx_req(tx0_req),
        .tx_flit(tx0_flit),
        .tx_ack(tx0_ack),
        .rx_req(rx0_req),
        .rx_flit(rx0_flit),
        .rx_ack(rx0_ack),
        .packet_recv(packet_recv0)
    );

    endpoint #(
        .NODE_ID(1)
    ) ep1 (
        .clk(clk),
        .reset(reset),
        .bus_addr(bus1_addr),
        .bus_wen(bus1_wen),
        .bus_ren(bus1_ren),
        .bus_wdata(bus1_wdata),
        .bus_rdata(bus1_rdata),
        .bus_error(bus1_error),
        .bus_stall(bus1_stall),
        .tx_req(tx1_req),
        .tx_flit(tx1_flit),
        .tx_ack(tx1_ack),
        .rx_req(rx1_req),
        .rx_flit(rx1_flit),
        .rx_ack(rx1_ack),
        .packet_recv(packet_recv1)
    );

    // switch port n faces endpoint n in both directions.
    noc_switch noc (
        .clk(clk),
        .reset(reset),
        .in0_req(tx0_req),
        .in0_flit(tx0_flit),
        .in0_ack(tx0_ack),
        .in1_req(tx1_req),
        .in1_flit(tx1_flit),
        .in1_ack(tx1_ack),
        .out0_req(rx0_req),
        .out0_flit(rx0_flit),
        .out0_ack(rx0_ack),
        .out1_req(rx1_req),
        .out1_flit(rx1_flit),
        .out1_ack(rx1_ack)
    );
endmodule

`default_nettype wire

/* chiplet_types_pkg.sv */
`default_nettype none

`include "noc_settings.svh"

package chiplet_types_pkg;

    // header flit with the destination in the top bits.
    typedef struct packed {
        logic [`NOC_NODE_W-1:0] dest;   // destination node.
        logic [`NOC_NODE_W-1:0] src;    // source node.
        logic [7:0]             count;  // data flits that follow.
        logic [15:0]            tag;    // free for software.
    } flit_head_t;

    // one link word seen as a header or as a plain data word.
    typedef union packed {
        flit_head_t             head;
        logic [`NOC_FLIT_W-1:0] payload;
    } flit_u;

endpackage

`default_nettype wire

/* endpoint.sv */
`default_nettype none

`include "noc_settings.svh"

module endpoint #(
    parameter int NODE_ID = 0
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [31:0]            bus_addr,
    input  logic                   bus_wen,
    input  logic                   bus_ren,
    input  logic [`NOC_FLIT_W-1:0] bus_wdata,
    output logic [`NOC_FLIT_W-1:0] bus_rdata,
    output logic                   bus_error,
    output logic                   bus_stall,
    output logic                   tx_req,
    output logic [`NOC_FLIT_W-1:0] tx_flit,
    input  logic                   tx_ack,
    input  logic                   rx_req,
    input  logic [`NOC_FLIT_W-1:0] rx_flit,
    output logic                   rx_ack,
    output logic                   packet_recv
);
    import chiplet_types_pkg::*;

    localparam int ENTRY_W = `NOC_FLIT_W + 1;

    flit_u              bus_word;
    flit_u              rx_word;
    flit_head_t         tx_head;
    logic               count_ok;
    logic               tx_start;
    logic               tx_wen;
    logic               sending;
    logic               tx_busy;
    logic               fifo_wen;
    logic               fifo_ren;
    logic               fifo_full;
    logic               fifo_empty;
    logic [ENTRY_W-1:0] fifo_rdata;
    logic               front_head;
    logic [7:0]         rx_left;
    logic               rx_at_head;

    assign bus_word    = bus_wdata;
    assign rx_word     = rx_flit;
    assign count_ok    = (bus_word.head.count != 8'd0) &&
                         (bus_word.head.count <= `NOC_MAX_MSG_WORDS);
    assign front_head  = fifo_rdata[ENTRY_W-1];
    assign packet_recv = !fifo_empty;
    assign rx_at_head  = (rx_left == 8'd0);
    assign fifo_wen    = rx_req && !rx_ack && !fifo_full;  // full queue holds off ack.

    always_comb begin
        tx_head     = bus_word.head;
        tx_head.src = NODE_ID[`NOC_NODE_W-1:0];  // source is always this node.
    end

    sync_fifo #(
        .WIDTH(ENTRY_W),
        .DEPTH(`NOC_RX_DEPTH)
    ) rx_fifo (
        .clk(clk),
        .reset(reset),
        .wen(fifo_wen),
        .ren(fifo_ren),
        .wdata({rx_at_head, rx_flit}),
        .rdata(fifo_rdata),
        .full(fifo_full),
        .empty(fifo_empty)
    );

    tx_fsm tx (
        .clk(clk),
        .reset(reset),
        .start(tx_start),
        .head(tx_head),
        .wen(tx_wen),
        .wdata(bus_wdata),
        .sending(sending),
        .busy(tx_busy),
        .link_req(tx_req),
        .link_flit(tx_flit),
        .link_ack(tx_ack)
    );

    // the receive counter tells a header from its data words.
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_ack  <= 1'b0;
            rx_left <= 8'd0;
        end else if (fifo_wen) begin
            rx_ack  <= 1'b1;
            rx_left <= rx_at_head ? rx_word.head.count : rx_left - 1'b1;
        end else if (rx_ack && !rx_req) begin
            rx_ack <= 1'b0;
        end
    end

    always_comb begin
        bus_rdata = 32'hBAD1BAD1;
        bus_error = 1'b0;
        bus_stall = 1'b0;
        tx_start  = 1'b0;
        tx_wen    = 1'b0;
        fifo_ren  = 1'b0;
        if (bus_addr == `NOC_TX_SEND_ADDR) begin
            bus_rdata = {31'd0, sending};
            if (bus_wen) begin
                if (sending || !count_ok) begin
                    bus_error = 1'b1;  // one open message at a time.
                end else begin
                    tx_start = 1'b1;
                end
            end
        end else if (bus_wen && bus_addr == `NOC_TX_WRITE_ADDR) begin
            if (!sending) begin
                bus_error = 1'b1;
            end else if (tx_busy) begin
                bus_stall = 1'b1;      // previous flit still on the link.
            end else begin
                tx_wen = 1'b1;
            end
        end else if (bus_ren && bus_addr == `NOC_RX_READY_ADDR) begin
            bus_rdata = {31'd0, !fifo_empty};
        end else if (bus_ren && bus_addr == `NOC_RX_PAYLOAD_ADDR) begin
            if (!fifo_empty && !front_head) begin
                bus_rdata = fifo_rdata[`NOC_FLIT_W-1:0];
                fifo_ren  = 1'b1;
            end else begin
                bus_error = 1'b1;
            end
        end else if (bus_ren && bus_addr == `NOC_RX_METADATA_ADDR) begin
            if (!fifo_empty && front_head) begin
                bus_rdata = fifo_rdata[`NOC_FLIT_W-1:0];
                fifo_ren  = 1'b1;
            end else begin
                bus_error = 1'b1;
            end
        end else if (bus_wen || bus_ren) begin
            bus_error = 1'b1;
        end
    end
endmodule

`default_nettype wire

/* noc_settings.svh */
`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

// flit and bus data width.
`define NOC_FLIT_W 32

// node id width that matches the header fields.
`define NOC_NODE_W 4

// receive queue entries per endpoint.
`define NOC_RX_DEPTH 8

// largest data word count accepted in a header.
`define NOC_MAX_MSG_WORDS 16

`define NOC_TX_WRITE_ADDR    32'h0000
`define NOC_TX_SEND_ADDR     32'h0004
`define NOC_RX_READY_ADDR    32'h1000
`define NOC_RX_PAYLOAD_ADDR  32'h1004
`define NOC_RX_METADATA_ADDR 32'h1008

`endif

/* noc_switch.sv */
`default_nettype none

`include "noc_settings.svh"

module noc_switch (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in0_req,
    input  logic [`NOC_FLIT_W-1:0] in0_flit,
    output logic                   in0_ack,
    input  logic                   in1_req,
    input  logic [`NOC_FLIT_W-1:0] in1_flit,
    output logic                   in1_ack,
    output logic                   out0_req,
    output logic [`NOC_FLIT_W-1:0] out0_flit,
    input  logic                   out0_ack,
    output logic                   out1_req,
    output logic [`NOC_FLIT_W-1:0] out1_flit,
    input  logic                   out1_ack
);
    import chiplet_types_pkg::*;

    logic [1:0]             in_req;
    logic [1:0]             in_ack;
    logic [1:0]             out_req;
    logic [1:0]             out_ack;
    flit_u                  in_word [2];
    logic [`NOC_FLIT_W-1:0] out_word [2];
    logic [1:0]             in_owned;
    logic [1:0]             want [2];   // want[o][i] is set while input i waits on output o.
    logic [1:0]             grant;
    logic [1:0]             grant_sel;
    logic [1:0]             locked;
    logic [1:0]             owner;
    logic [1:0]             prio;
    logic [1:0]             ack_q;
    logic [7:0]             left [2];

    assign in_req     = {in1_req, in0_req};
    assign out_ack    = {out1_ack, out0_ack};
    assign in_word[0] = in0_flit;
    assign in_word[1] = in1_flit;
    assign in0_ack    = in_ack[0];
    assign in1_ack    = in_ack[1];
    assign out0_req   = out_req[0];
    assign out1_req   = out_req[1];
    assign out0_flit  = out_word[0];
    assign out1_flit  = out_word[1];

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            in_owned[i] = (locked[0] && owner[0] == i) || (locked[1] && owner[1] == i);
            in_ack[i]   = (locked[0] && owner[0] == i && out_ack[0]) ||
                          (locked[1] && owner[1] == i && out_ack[1]);
        end
        for (int o = 0; o < 2; o++) begin
            out_req[o]  = locked[o] && in_req[owner[o]];
            out_word[o] = in_word[owner[o]].payload;
            // a free input with req up is showing a header; low dest bit picks the port.
            for (int i = 0; i < 2; i++) begin
                want[o][i] = in_req[i] && !in_owned[i] && (in_word[i].head.dest[0] == o);
            end
            grant[o]     = !locked[o] && (want[o] != 2'b00);
            grant_sel[o] = want[o][prio[o]] ? prio[o] : !prio[o];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            locked  <= 2'b00;
            owner   <= 2'b00;
            prio    <= 2'b00;
            ack_q   <= 2'b00;
            left[0] <= 8'd0;
            left[1] <= 8'd0;
        end else begin
            ack_q <= out_ack;
            for (int o = 0; o < 2; o++) begin
                if (grant[o]) begin
                    locked[o] <= 1'b1;
                    owner[o]  <= grant_sel[o];
                    prio[o]   <= !grant_sel[o];   // other input goes first next time.
                    left[o]   <= in_word[grant_sel[o]].head.count;
                end else if (locked[o] && ack_q[o] && !out_ack[o]) begin
                    if (left[o] == 8'd0) begin
                        locked[o] <= 1'b0;        // whole message delivered.
                    end else begin
                        left[o] <= left[o] - 1'b1;
                    end
                end
            end
        end
    end
endmodule

`default_nettype wire

/* sim.f */
+incdir+.
chiplet_types_pkg.sv
sync_fifo.sv
tx_fsm.sv
endpoint.sv
noc_switch.sv
chiplet_node_top.sv
tb_chiplet_node.sv

/* sync_fifo.sv */
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 8
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             wen,
    input  logic             ren,
    input  logic [WIDTH-1:0] wdata,
    output logic [WIDTH-1:0] rdata,
    output logic             full,
    output logic             empty
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_write;
    logic             do_read;

    assign full     = (count == (PTR_W+1)'(DEPTH));
    assign empty    = (count == '0);
    assign do_write = wen && !full;     // a write to a full buffer is dropped.
    assign do_read  = ren && !empty;
    assign rdata    = mem[rd_ptr];      // front entry is visible without a read.

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end
endmodule

`default_nettype wire

/* tb_chiplet_node.sv */
`default_nettype none

`include "noc_settings.svh"

module tb_chiplet_node;
    localparam logic [1:0] OP_READ      = 2'd0;
    localparam logic [1:0] OP_WRITE     = 2'd1;
    localparam logic [1:0] OP_WAIT_RECV = 2'd2;
    localparam logic [1:0] OP_WAIT_IDLE = 2'd3;

    typedef struct packed {
        logic        node;
        logic [1:0]  op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic        err;
        logic        skip;   // rdata not checked.
    } row_t;

    logic        clk;
    logic        reset;
    logic [31:0] bus0_addr;
    logic        bus0_wen;
    logic        bus0_ren;
    logic [31:0] bus0_wdata;
    logic [31:0] bus0_rdata;
    logic        bus0_error;
    logic        bus0_stall;
    logic [31:0] bus1_addr;
    logic        bus1_wen;
    logic        bus1_ren;
    logic [31:0] bus1_wdata;
    logic [31:0] bus1_rdata;
    logic        bus1_error;
    logic        bus1_stall;
    logic        packet_recv0;
    logic        packet_recv1;

    row_t rows [$];
    int   stall_run [2];
    int   err_count;
    int   test_errors;
    int   pass_count;
    int   fail_count;

    chiplet_node_top uut (
        .clk(clk),
        .reset(reset),
        .bus0_addr(bus0_addr),
        .bus0_wen(bus0_wen),
        .bus0_ren(bus0_ren),
        .bus0_wdata(bus0_wdata),
        .bus0_rdata(bus0_rdata),
        .bus0_error(bus0_error),
        .bus0_stall(bus0_stall),
        .bus1_addr(bus1_addr),
        .bus1_wen(bus1_wen),
        .bus1_ren(bus1_ren),
        .bus1_wdata(bus1_wdata),
        .bus1_rdata(bus1_rdata),
        .bus1_error(bus1_error),
        .bus1_stall(bus1_stall),
        .packet_recv0(packet_recv0),
        .packet_recv1(packet_recv1)
    );

    always #10 clk = ~clk;

    // dest, src, count and tag from the top bit down.
    function automatic logic [31:0] head_word(input logic [3:0] dest, input logic [3:0] src,
                                              input logic [7:0] count, input logic [15:0] tag);
        return {dest, src, count, tag};
    endfunction

    function automatic void add_row(input logic node, input logic [1:0] op,
                                    input logic [31:0] addr, input logic [31:0] wdata,
                                    input logic [31:0] rdata, input logic err, input logic skip);
        row_t r;
        r = '{node: node, op: op, addr: addr, wdata: wdata, rdata: rdata, err: err, skip: skip};
        rows.push_back(r);
    endfunction

    function automatic void write_row(input logic node, input logic [31:0] addr,
                                      input logic [31:0] wdata, input logic err);
        add_row(node, OP_WRITE, addr, wdata, 32'h0, err, 1'b1);
    endfunction

    function automatic void read_row(input logic node, input logic [31:0] addr,
                                     input logic [31:0] rdata, input logic err, input logic skip);
        add_row(node, OP_READ, addr, 32'h0, rdata, err, skip);
    endfunction

    function automatic void wait_row(input logic node, input logic [1:0] op);
        add_row(node, op, 32'h0, 32'h0, 32'h0, 1'b0, 1'b1);
    endfunction

    task automatic check_value(input string name, input logic node,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %0t bus%0d_%s expected %h got %h", $time, node, name, expected, actual);
            err_count++;
        end
    endtask

    task automatic set_bus(input logic node, input logic wen, input logic ren,
                           input logic [31:0] addr, input logic [31:0] wdata);
        if (node) begin
            bus1_addr  = addr;
            bus1_wen   = wen;
            bus1_ren   = ren;
            bus1_wdata = wdata;
        end else begin
            bus0_addr  = addr;
            bus0_wen   = wen;
            bus0_ren   = ren;
            bus0_wdata = wdata;
        end
    endtask

    // starts and ends 2 units after a rising edge.
    task automatic bus_access(input logic node, input logic write, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic error, output logic ok);
        int cycles;
        cycles = 0;
        ok     = 1'b0;
        rdata  = 32'hffff_ffff;
        error  = 1'b1;
        set_bus(node, write, !write, addr, wdata);
        while (!ok && cycles < 200) begin
            @(negedge clk);
            if (node ? bus1_stall : bus0_stall) begin
                stall_run[node] = stall_run[node] + 1;   // request held for another try.
            end else begin
                ok              = 1'b1;
                stall_run[node] = 0;
                rdata           = node ? bus1_rdata : bus0_rdata;
                error           = node ? bus1_error : bus0_error;
            end
            @(posedge clk);
            #2;
            cycles++;
        end
        set_bus(node, 1'b0, 1'b0, 32'h0, 32'h0);
        if (!ok) begin
            $display("bus access on node %0d at address %h still stalled after 200 cycles",
                     node, addr);
            err_count++;
        end
    endtask

    task automatic await_packet(input logic node);
        int cycles;
        cycles = 0;
        while (!(node ? packet_recv1 : packet_recv0) && cycles < 2000) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (!(node ? packet_recv1 : packet_recv0)) begin
            $display("timeout waiting 2000 cycles for packet_recv%0d to rise", node);
            err_count++;
        end
    endtask

    // sending drops once the last data flit sits in the far queue.
    task automatic poll_send_idle(input logic node);
        int          polls;
        logic [31:0] rdata;
        logic        error;
        logic        ok;
        polls = 0;
        rdata = 32'h1;
        ok    = 1'b1;
        while (rdata[0] && ok && polls < 2000) begin
            bus_access(node, 1'b0, `NOC_TX_SEND_ADDR, 32'h0, rdata, error, ok);
            polls++;
        end
        if (rdata[0]) begin
            $display("timeout waiting for node %0d to finish sending its message", node);
            err_count++;
        end
    endtask

    task automatic watch_stall(input logic node, input int min_run);
        int cycles;
        cycles = 0;
        while (stall_run[node] < min_run && cycles < 2000) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (stall_run[node] < min_run) begin
            $display("no long stall seen on node %0d bus within 2000 cycles", node);
            err_count++;
        end
    endtask

    task automatic run_rows(input int first, input int last);
        logic [31:0] rdata;
        logic        error;
        logic        ok;
        row_t        r;
        for (int i = first; i < last; i++) begin
            r = rows[i];
            case (r.op)
                OP_READ, OP_WRITE: begin
                    bus_access(r.node, r.op == OP_WRITE, r.addr, r.wdata, rdata, error, ok);
                    if (ok) begin
                        check_value("error", r.node, {31'd0, r.err}, {31'd0, error});
                        if (!r.skip) begin
                            check_value("rdata", r.node, r.rdata, rdata);
                        end
                    end
                end
                OP_WAIT_RECV: await_packet(r.node);
                default:      poll_send_idle(r.node);
            endcase
        end
    endtask

    task automatic end_test(input string name);
        if (err_count == test_errors) begin
            pass_count++;
            $display("test %s: passed", name);
        end else begin
            fail_count++;
            $display("test %s: failed with %0d errors", name, err_count - test_errors);
        end
        test_errors = err_count;
        rows.delete();
    endtask

    initial begin
        logic [31:0] heads [2];
        logic [31:0] data [2][16];
        logic [31:0] word;
        logic [31:0] rdata;
        logic        error;
        logic        ok;
        int          first;
        int          split;

        void'($urandom(32'hfe1a));
        clk         = 1'b0;
        reset       = 1'b1;
        err_count   = 0;
        test_errors = 0;
        pass_count  = 0;
        fail_count  = 0;
        stall_run   = '{0, 0};
        set_bus(1'b0, 1'b0, 1'b0, 32'h0, 32'h0);
        set_bus(1'b1, 1'b0, 1'b0, 32'h0, 32'h0);
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;

        if (packet_recv0 !== 1'b0) begin
            $display("ERR %0t packet_recv0 expected 0 got %b", $time, packet_recv0);
            err_count++;
        end
        if (packet_recv1 !== 1'b0) begin
            $display("ERR %0t packet_recv1 expected 0 got %b", $time, packet_recv1);
            err_count++;
        end
        for (int n = 0; n < 2; n++) begin
            read_row(n[0], `NOC_TX_SEND_ADDR, 32'h0, 1'b0, 1'b0);
            read_row(n[0], `NOC_RX_READY_ADDR, 32'h0, 1'b0, 1'b0);
        end
        run_rows(0, rows.size());
        end_test("after reset");

        write_row(1'b0, `NOC_TX_SEND_ADDR, head_word(4'd1, 4'd7, 8'd3, 16'h5a01), 1'b0);
        for (int k = 0; k < 3; k++) begin
            data[0][k] = $urandom;
            write_row(1'b0, `NOC_TX_WRITE_ADDR, data[0][k], 1'b0);
        end
        wait_row(1'b0, OP_WAIT_IDLE);
        wait_row(1'b1, OP_WAIT_RECV);
        read_row(1'b1, `NOC_RX_METADATA_ADDR, head_word(4'd1, 4'd0, 8'd3, 16'h5a01), 1'b0, 1'b0);
        for (int k = 0; k < 3; k++) begin
            read_row(1'b1, `NOC_RX_PAYLOAD_ADDR, data[0][k], 1'b0, 1'b0);
        end
        read_row(1'b1, `NOC_RX_READY_ADDR, 32'h0, 1'b0, 1'b0);
        run_rows(0, rows.size());
        end_test("node 0 to node 1");

        word = $urandom;
        write_row(1'b0, `NOC_TX_WRITE_ADDR, word, 1'b1);
        read_row(1'b1, `NOC_RX_PAYLOAD_ADDR, 32'h0, 1'b1, 1'b1);
        write_row(1'b0, `NOC_TX_SEND_ADDR, head_word(4'd1, 4'd0, 8'd0, 16'h0e00), 1'b1);
        read_row(1'b0, `NOC_TX_SEND_ADDR, 32'h0, 1'b0, 1'b0);
        write_row(1'b0, `NOC_TX_SEND_ADDR, head_word(4'd1, 4'd0, 8'd1, 16'h0e01), 1'b0);
        write_row(1'b0, `NOC_TX_SEND_ADDR, head_word(4'd1, 4'd0, 8'd2, 16'h0e02), 1'b1);
        write_row(1'b0, `NOC_TX_WRITE_ADDR, word, 1'b0);
        wait_row(1'b0, OP_WAIT_IDLE);
        wait_row(1'b1, OP_WAIT_RECV);
        read_row(1'b1, `NOC_RX_METADATA_ADDR, head_word(4'd1, 4'd0, 8'd1, 16'h0e01), 1'b0, 1'b0);
        read_row(1'b1, `NOC_RX_METADATA_ADDR, 32'h0, 1'b1, 1'b1);  // front is a data word.
        read_row(1'b1, `NOC_RX_PAYLOAD_ADDR, word, 1'b0, 1'b0);
        read_row(1'b1, `NOC_RX_READY_ADDR, 32'h0, 1'b0, 1'b0);
        read_row(1'b0, 32'h2000, 32'hBAD1BAD1, 1'b1, 1'b0);
        write_row(1'b0, 32'h2000, word, 1'b1);
        run_rows(0, rows.size());
        end_test("errors");

        heads[0] = head_word(4'd1, 4'd0, 8'd2, 16'hc0a0);
        heads[1] = head_word(4'd1, 4'd1, 8'd2, 16'hc1a1);
        for (int n = 0; n < 2; n++) begin
            write_row(n[0], `NOC_TX_SEND_ADDR, heads[n], 1'b0);
        end
        for (int n = 0; n < 2; n++) begin
            for (int k = 0; k < 2; k++) begin
                data[n][k] = $urandom;
                write_row(n[0], `NOC_TX_WRITE_ADDR, data[n][k], 1'b0);
            end
        end
        wait_row(1'b0, OP_WAIT_IDLE);
        wait_row(1'b1, OP_WAIT_IDLE);
        wait_row(1'b1, OP_WAIT_RECV);
        run_rows(0, rows.size());
        rows.delete();
        // either sender may win the output.
        first = 0;
        bus_access(1'b1, 1'b0, `NOC_RX_METADATA_ADDR, 32'h0, rdata, error, ok);
        check_value("error", 1'b1, 32'h0, {31'd0, error});
        if (rdata === heads[1]) begin
            first = 1;
        end else if (rdata !== heads[0]) begin
            $display("ERR %0t bus1_rdata expected %h or %h got %h",
                     $time, heads[0], heads[1], rdata);
            err_count++;
        end
        for (int k = 0; k < 2; k++) begin
            read_row(1'b1, `NOC_RX_PAYLOAD_ADDR, data[first][k], 1'b0, 1'b0);
        end
        read_row(1'b1, `NOC_RX_METADATA_ADDR, heads[1 - first], 1'b0, 1'b0);
        for (int k = 0; k < 2; k++) begin
            read_row(1'b1, `NOC_RX_PAYLOAD_ADDR, data[1 - first][k], 1'b0, 1'b0);
        end
        read_row(1'b1, `NOC_RX_READY_ADDR, 32'h0, 1'b0, 1'b0);
        run_rows(0, rows.size());
        end_test("contention");

        write_row(1'b1, `NOC_TX_SEND_ADDR, head_word(4'd0, 4'd3, 8'd16, 16'hbb05), 1'b0);
        for (int k = 0; k < 16; k++) begin
            data[1][k] = $urandom;
            write_row(1'b1, `NOC_TX_WRITE_ADDR, data[1][k], 1'b0);
        end
        wait_row(1'b1, OP_WAIT_IDLE);
        split = rows.size();
        for (int k = 0; k < 17; k++) begin
            wait_row(1'b0, OP_WAIT_RECV);
            if (k == 0) begin
                read_row(1'b0, `NOC_RX_METADATA_ADDR, head_word(4'd0, 4'd1, 8'd16, 16'hbb05),
                         1'b0, 1'b0);
            end else begin
                read_row(1'b0, `NOC_RX_PAYLOAD_ADDR, data[1][k - 1], 1'b0, 1'b0);
            end
        end
        read_row(1'b0, `NOC_RX_READY_ADDR, 32'h0, 1'b0, 1'b0);
        stall_run = '{0, 0};
        fork
            run_rows(0, split);
            begin
                watch_stall(1'b1, 20);   // node 0 queue fills and node 1 is held off.
                if (packet_recv0 !== 1'b1) begin
                    $display("ERR %0t packet_recv0 expected 1 got %b", $time, packet_recv0);
                    err_count++;
                end
                run_rows(split, rows.size());
            end
        join
        end_test("back-pressure");

        $display("tests passed %0d failed %0d, errors %0d", pass_count, fail_count, err_count);
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end
endmodule

`default_nettype wire

/* tx_fsm.sv */
`default_nettype none

`include "noc_settings.svh"

module tx_fsm (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start,
    input  chiplet_types_pkg::flit_head_t head,
    input  logic                          wen,
    input  logic [`NOC_FLIT_W-1:0]        wdata,
    output logic                          sending,
    output logic                          busy,
    output logic                          link_req,
    output logic [`NOC_FLIT_W-1:0]        link_flit,
    input  logic                          link_ack
);
    import chiplet_types_pkg::*;

    localparam logic [1:0] LINK_IDLE = 2'd0;
    localparam logic [1:0] LINK_REQ  = 2'd1;
    localparam logic [1:0] LINK_DROP = 2'd2;

    logic [1:0] link_state;
    flit_u      flit_q;
    logic       flit_full;
    logic       flit_is_head;
    logic [7:0] words_left;
    logic       load_head;
    logic       load_data;

    assign busy      = flit_full || (link_state != LINK_IDLE);
    assign load_head = start && !busy;
    assign load_data = wen && !busy && !start;
    assign link_req  = (link_state == LINK_REQ);
    assign link_flit = flit_q.payload;

    always_ff @(posedge clk) begin
        if (load_head) begin
            flit_q.head <= head;
        end else if (load_data) begin
            flit_q.payload <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            link_state   <= LINK_IDLE;
            flit_full    <= 1'b0;
            flit_is_head <= 1'b0;
            words_left   <= 8'd0;
            sending      <= 1'b0;
        end else begin
            if (load_head) begin
                flit_full    <= 1'b1;
                flit_is_head <= 1'b1;
                words_left   <= head.count;
                sending      <= 1'b1;
            end else if (load_data) begin
                flit_full    <= 1'b1;
                flit_is_head <= 1'b0;
            end
            case (link_state)
                LINK_IDLE: begin
                    if (flit_full && !link_ack) begin
                        link_state <= LINK_REQ;
                    end
                end
                LINK_REQ: begin
                    if (link_ack) begin
                        link_state <= LINK_DROP;
                        flit_full  <= 1'b0;       // receiver has the flit.
                        if (!flit_is_head) begin
                            words_left <= words_left - 1'b1;
                        end
                    end
                end
                LINK_DROP: begin
                    if (!link_ack) begin
                        link_state <= LINK_IDLE;
                        if (words_left == 8'd0) begin
                            sending <= 1'b0;      // last data flit done.
                        end
                    end
                end
                default: link_state <= LINK_IDLE;
            endcase
        end
    end
endmodule

`default_nettype wire
